// ==== rtl/display_pkg.sv ====
// ********************
// 640x480 VGA timing constants and screen coordinates
// ********************
package display_pkg;

    typedef logic [9:0] scr_coord_t;  // screen x or y

    localparam scr_coord_t h_active     = 10'd640;
    localparam scr_coord_t h_sync_start = 10'd656;
    localparam scr_coord_t h_sync_end   = 10'd751;
    localparam scr_coord_t h_total      = 10'd800;

    localparam scr_coord_t v_active     = 10'd480;
    localparam scr_coord_t v_sync_start = 10'd490;
    localparam scr_coord_t v_sync_end   = 10'd491;
    localparam scr_coord_t v_total      = 10'd525;

    localparam logic sync_active = 1'b0;  // both syncs active low

endpackage

// ==== rtl/render_pkg.sv ====
// ********************
// model, framebuffer, angle and colour types for the renderer
// ********************
package render_pkg;

    localparam int fb_width  = 160;
    localparam int fb_height = 120;
    localparam int fb_scale  = 4;  // framebuffer pixel to screen pixels

    typedef logic signed [15:0] fb_coord_t;
    typedef logic [14:0]        fb_addr_t;  // y * fb_width + x
    typedef logic [3:0]         cidx_t;
    typedef logic [11:0]        rgb_t;      // {r, g, b}
    typedef logic [5:0]         angle_t;    // 64 steps per turn
    typedef logic signed [15:0] fixp_t;     // Q8.8
    typedef logic signed [7:0]  trig_t;     // Q1.7

    localparam int line_cnt = 12;
    typedef logic [3:0] line_id_t;

    typedef enum logic [1:0] {axis_none, axis_x, axis_y, axis_z} axis_t;

    // view centre in framebuffer coordinates
    localparam fb_coord_t view_cx = 16'sd80;
    localparam fb_coord_t view_cy = 16'sd60;

    localparam rgb_t palette [16] = '{
        12'h000, 12'h123, 12'h725, 12'h085,
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h3AF, 12'h879, 12'hF7A, 12'hFCA
    };

    typedef enum logic [3:0] {
        st_idle, st_init, st_rom_wait, st_load,
        st_rot_x0, st_rot_y0, st_rot_z0,
        st_rot_x1, st_rot_y1, st_rot_z1,
        st_view, st_draw, st_next
    } render_state_t;

endpackage

// ==== rtl/display_timings.sv ====
// ********************
// 640x480 scan counters with syncs, data enable and frame pulse
// ********************
`timescale 1ns/1ps

module display_timings import display_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    output scr_coord_t sx,
    output scr_coord_t sy,
    output logic       de,
    output logic       hsync,
    output logic       vsync,
    output logic       frame
);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == h_total - 10'd1) begin  // end of line
            sx <= '0;
            sy <= (sy == v_total - 10'd1) ? '0 : sy + 10'd1;
        end else begin
            sx <= sx + 10'd1;
        end
    end

    always_comb begin
        de = (sx < h_active) && (sy < v_active);
        if (sx >= h_sync_start && sx <= h_sync_end) begin
            hsync = sync_active;
        end else begin
            hsync = ~sync_active;
        end
        if (sy >= v_sync_start && sy <= v_sync_end) begin
            vsync = sync_active;
        end else begin
            vsync = ~sync_active;
        end
        frame = (sx == '0) && (sy == v_active);  // start of vertical blank
    end

endmodule

// ==== rtl/framebuffer.sv ====
// ********************
// pixel memory with draw port, 4x scanout and palette to VGA
// ********************
`timescale 1ns/1ps

module framebuffer import display_pkg::*, render_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    input  scr_coord_t sx,
    input  scr_coord_t sy,
    input  logic       de,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       we,
    input  fb_coord_t  px,
    input  fb_coord_t  py,
    input  cidx_t      cidx,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_hsync,
    output logic       vga_vsync
);

    cidx_t    fb_mem [fb_width*fb_height];
    fb_addr_t waddr;
    fb_addr_t raddr;
    logic     in_bounds;
    cidx_t    rd_cidx;
    rgb_t     rgb;
    logic     de_p1;
    logic     hsync_p1;
    logic     vsync_p1;

    initial begin
        for (int i = 0; i < fb_width*fb_height; i++) begin
            fb_mem[i] = '0;
        end
    end

    always_comb begin
        in_bounds = (px >= 0) && (px < fb_width) && (py >= 0) && (py < fb_height);
        waddr     = fb_addr_t'(py * fb_width + px);
        raddr     = fb_addr_t'((sy / fb_scale) * fb_width + sx / fb_scale);
        rgb       = palette[rd_cidx];
    end

    always_ff @(posedge clk_pix) begin
        if (we && in_bounds) begin  // clip off-screen pixels
            fb_mem[waddr] <= cidx;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (de) begin
            rd_cidx <= fb_mem[raddr];
        end
    end

    // second stage lines up syncs with the colour
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            de_p1     <= 1'b0;
            hsync_p1  <= ~sync_active;
            vsync_p1  <= ~sync_active;
            vga_hsync <= ~sync_active;
            vga_vsync <= ~sync_active;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            de_p1     <= de;
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= de_p1 ? rgb[11:8] : 4'h0;  // black in blanking
            vga_g     <= de_p1 ? rgb[7:4]  : 4'h0;
            vga_b     <= de_p1 ? rgb[3:0]  : 4'h0;
        end
    end

endmodule

// ==== rtl/rotate.sv ====
// ********************
// rotates a Q8.8 point about one axis in two cycles
// ********************
`timescale 1ns/1ps

module rotate import render_pkg::*; (
    input  logic   clk_pix,
    input  logic   reset,
    input  logic   start,
    input  axis_t  axis,
    input  angle_t angle,
    input  fixp_t  x,
    input  fixp_t  y,
    input  fixp_t  z,
    output fixp_t  xr,
    output fixp_t  yr,
    output fixp_t  zr,
    output logic   done
);

    trig_t sin_tab [17];  // quarter wave, sin(pi*k/32)

    initial $readmemh("sine.mem", sin_tab);

    function automatic trig_t sin_of(input angle_t a);
        logic [3:0] i;
        logic [4:0] j;
        i = a[3:0];
        j = 5'd16 - {1'b0, i};
        case (a[5:4])  // quadrant fold
            2'd0:    sin_of = sin_tab[i];
            2'd1:    sin_of = sin_tab[j];
            2'd2:    sin_of = -sin_tab[i];
            default: sin_of = -sin_tab[j];
        endcase
    endfunction

    trig_t              sin_a;
    trig_t              cos_a;
    fixp_t              u;
    fixp_t              v;
    logic signed [23:0] p_uc, p_vs, p_us, p_vc;
    logic signed [24:0] sum_u, sum_v;
    fixp_t              x_q, y_q, z_q;
    axis_t              axis_q;
    logic               busy_p1;

    always_comb begin
        sin_a = sin_of(angle);
        cos_a = sin_of(angle + 6'd16);
        case (axis)  // pair that turns
            axis_x: begin
                u = y;
                v = z;
            end
            axis_y: begin
                u = z;
                v = x;
            end
            default: begin
                u = x;
                v = y;
            end
        endcase
        sum_u = p_uc - p_vs;
        sum_v = p_us + p_vc;
    end

    // first cycle multiplies
    always_ff @(posedge clk_pix) begin
        if (start) begin
            p_uc   <= u * cos_a;
            p_vs   <= v * sin_a;
            p_us   <= u * sin_a;
            p_vc   <= v * cos_a;
            x_q    <= x;
            y_q    <= y;
            z_q    <= z;
            axis_q <= axis;
        end
    end

    // second cycle sums, >>> 7 rounds down
    always_ff @(posedge clk_pix) begin
        if (busy_p1) begin
            case (axis_q)
                axis_x: begin
                    xr <= x_q;
                    yr <= sum_u[22:7];
                    zr <= sum_v[22:7];
                end
                axis_y: begin
                    xr <= sum_v[22:7];
                    yr <= y_q;
                    zr <= sum_u[22:7];
                end
                axis_z: begin
                    xr <= sum_u[22:7];
                    yr <= sum_v[22:7];
                    zr <= z_q;
                end
                default: begin
                    xr <= x_q;
                    yr <= y_q;
                    zr <= z_q;
                end
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            busy_p1 <= 1'b0;
            done    <= 1'b0;
        end else begin
            busy_p1 <= start;
            done    <= busy_p1;
        end
    end

endmodule

// ==== rtl/draw_line.sv ====
// ********************
// Bresenham line generator, one pixel per cycle
// ********************
`timescale 1ns/1ps

module draw_line import render_pkg::*; (
    input  logic      clk_pix,
    input  logic      reset,
    input  logic      start,
    input  fb_coord_t x0,
    input  fb_coord_t y0,
    input  fb_coord_t x1,
    input  fb_coord_t y1,
    output fb_coord_t x,
    output fb_coord_t y,
    output logic      drawing,
    output logic      done
);

    typedef enum logic [1:0] {dl_idle, dl_init, dl_draw} dl_state_t;

    dl_state_t state;
    fb_coord_t xe, ye;    // end point
    fb_coord_t dx, dy;    // dy is negative
    logic      x_neg, y_neg;
    fb_coord_t e, e_cur, e2, e_next;
    fb_coord_t x_next, y_next;
    logic      last;

    always_comb begin
        e_cur  = (state == dl_init) ? fb_coord_t'(dx + dy) : e;  // first error term
        e2     = e_cur <<< 1;
        last   = (x == xe) && (y == ye);
        e_next = e_cur;
        x_next = x;
        y_next = y;
        if (e2 >= dy) begin
            e_next = e_next + dy;
            x_next = x_neg ? x - 16'sd1 : x + 16'sd1;
        end
        if (e2 <= dx) begin
            e_next = e_next + dx;
            y_next = y_neg ? y - 16'sd1 : y + 16'sd1;
        end
    end

    assign drawing = (state != dl_idle);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= dl_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                dl_idle: begin
                    if (start) begin
                        x     <= x0;
                        y     <= y0;
                        xe    <= x1;
                        ye    <= y1;
                        x_neg <= (x1 < x0);
                        y_neg <= (y1 < y0);
                        dx    <= (x1 < x0) ? x0 - x1 : x1 - x0;
                        dy    <= (y1 < y0) ? y1 - y0 : y0 - y1;
                        state <= dl_init;
                    end
                end
                default: begin  // init and draw both emit a pixel
                    if (last) begin
                        done  <= 1'b1;
                        state <= dl_idle;
                    end else begin
                        x     <= x_next;
                        y     <= y_next;
                        e     <= e_next;
                        state <= dl_draw;
                    end
                end
            endcase
        end
    end

endmodule

// ==== rtl/render_config.sv ====
// ********************
// angle and colour registers with render request
// ********************
`timescale 1ns/1ps

module render_config import render_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_data,
    output angle_t     angle_x,
    output angle_t     angle_y,
    output angle_t     angle_z,
    output cidx_t      colour,
    output logic       render_req
);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            angle_x    <= '0;
            angle_y    <= '0;
            angle_z    <= '0;
            colour     <= 4'hf;
            render_req <= 1'b0;
        end else begin
            render_req <= 1'b0;
            if (cfg_we) begin
                case (cfg_addr)
                    2'd0: angle_x <= cfg_data[5:0];
                    2'd1: angle_y <= cfg_data[5:0];
                    2'd2: angle_z <= cfg_data[5:0];
                    default: begin  // colour write kicks a render
                        colour     <= cfg_data[3:0];
                        render_req <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/render_control.sv ====
// ********************
// model ROM and sequencer for rotate, view and draw of each line
// ********************
`timescale 1ns/1ps

module render_control import render_pkg::*; (
    input  logic      clk_pix,
    input  logic      reset,
    input  logic      frame,
    input  logic      render_req,
    input  angle_t    angle_x,
    input  angle_t    angle_y,
    input  angle_t    angle_z,
    input  cidx_t     colour,
    output logic      busy,
    output cidx_t     draw_cidx,
    output fb_coord_t px,
    output fb_coord_t py,
    output logic      drawing
);

    logic [47:0]       model_rom [line_cnt];  // {x0,y0,z0,x1,y1,z1}
    logic [47:0]       rom_data;
    line_id_t          line_id;
    render_state_t     state;
    logic              pending;
    angle_t            ang_x, ang_y, ang_z;
    logic signed [7:0] lx1, ly1, lz1;
    fb_coord_t         x0, y0, x1, y1;  // rotated integer coords
    fb_coord_t         xv0, yv0, xv1, yv1;
    axis_t             rot_axis;
    angle_t            rot_angle;
    fixp_t             rot_x, rot_y, rot_z;
    fixp_t             rot_xr, rot_yr, rot_zr;
    logic              rot_start, rot_done;
    logic              draw_start, draw_done;

    initial $readmemh("cube.mem", model_rom);

    always_ff @(posedge clk_pix) begin
        rom_data <= model_rom[line_id];
    end

    always_comb begin
        case (rot_axis)
            axis_x:  rot_angle = ang_x;
            axis_y:  rot_angle = ang_y;
            default: rot_angle = ang_z;
        endcase
    end

    assign busy = (state != st_idle);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state      <= st_idle;
            pending    <= 1'b0;
            line_id    <= '0;
            rot_start  <= 1'b0;
            draw_start <= 1'b0;
        end else begin
            rot_start  <= 1'b0;
            draw_start <= 1'b0;
            if (render_req) begin
                pending <= 1'b1;
            end else if (state == st_idle && frame) begin
                pending <= 1'b0;
            end
            case (state)
                st_idle: if (frame && pending) state <= st_init;
                st_init: begin  // snapshot config for this render
                    ang_x     <= angle_x;
                    ang_y     <= angle_y;
                    ang_z     <= angle_z;
                    draw_cidx <= colour;
                    line_id   <= '0;
                    state     <= st_rom_wait;
                end
                st_rom_wait: state <= st_load;
                st_load: begin
                    rot_x     <= fixp_t'({rom_data[47:40], 8'h00});
                    rot_y     <= fixp_t'({rom_data[39:32], 8'h00});
                    rot_z     <= fixp_t'({rom_data[31:24], 8'h00});
                    lx1       <= rom_data[23:16];
                    ly1       <= rom_data[15:8];
                    lz1       <= rom_data[7:0];
                    rot_axis  <= axis_x;
                    rot_start <= 1'b1;
                    state     <= st_rot_x0;
                end
                st_rot_x0, st_rot_y0, st_rot_x1, st_rot_y1: begin
                    if (rot_done) begin  // feed back for next axis
                        rot_x     <= rot_xr;
                        rot_y     <= rot_yr;
                        rot_z     <= rot_zr;
                        rot_axis  <= (rot_axis == axis_x) ? axis_y : axis_z;
                        rot_start <= 1'b1;
                        state     <= state.next();
                    end
                end
                st_rot_z0: begin
                    if (rot_done) begin
                        x0        <= rot_xr >>> 8;  // floor of Q8.8
                        y0        <= rot_yr >>> 8;
                        rot_x     <= fixp_t'({lx1, 8'h00});
                        rot_y     <= fixp_t'({ly1, 8'h00});
                        rot_z     <= fixp_t'({lz1, 8'h00});
                        rot_axis  <= axis_x;
                        rot_start <= 1'b1;
                        state     <= st_rot_x1;
                    end
                end
                st_rot_z1: begin
                    if (rot_done) begin
                        x1    <= rot_xr >>> 8;
                        y1    <= rot_yr >>> 8;
                        state <= st_view;
                    end
                end
                st_view: begin
                    xv0        <= x0 + view_cx;
                    yv0        <= view_cy - y0;  // y up the screen
                    xv1        <= x1 + view_cx;
                    yv1        <= view_cy - y1;
                    draw_start <= 1'b1;
                    state      <= st_draw;
                end
                st_draw: if (draw_done) state <= st_next;
                default: begin  // next line or finish
                    if (line_id == line_id_t'(line_cnt - 1)) begin
                        state <= st_idle;
                    end else begin
                        line_id <= line_id + 4'd1;
                        state   <= st_rom_wait;
                    end
                end
            endcase
        end
    end

    rotate i_rotate (
        .clk_pix (clk_pix),
        .reset   (reset),
        .start   (rot_start),
        .axis    (rot_axis),
        .angle   (rot_angle),
        .x       (rot_x),
        .y       (rot_y),
        .z       (rot_z),
        .xr      (rot_xr),
        .yr      (rot_yr),
        .zr      (rot_zr),
        .done    (rot_done)
    );

    draw_line i_draw_line (
        .clk_pix (clk_pix),
        .reset   (reset),
        .start   (draw_start),
        .x0      (xv0),
        .y0      (yv0),
        .x1      (xv1),
        .y1      (yv1),
        .x       (px),
        .y       (py),
        .drawing (drawing),
        .done    (draw_done)
    );

endmodule

// ==== rtl/cube_top.sv ====
// ********************
// wireframe cube renderer with VGA scanout
// ********************
`timescale 1ns/1ps

module cube_top import display_pkg::*, render_pkg::*; (
    input  logic       clk_pix,
    input  logic       reset,
    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  logic [7:0] cfg_data,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       busy
);

    scr_coord_t sx, sy;
    logic       de, hsync, vsync, frame;
    angle_t     angle_x, angle_y, angle_z;
    cidx_t      colour;
    logic       render_req;
    cidx_t      draw_cidx;
    fb_coord_t  px, py;
    logic       drawing;

    display_timings i_display_timings (
        .clk_pix (clk_pix),
        .reset   (reset),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync),
        .frame   (frame)
    );

    render_config i_render_config (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .angle_x    (angle_x),
        .angle_y    (angle_y),
        .angle_z    (angle_z),
        .colour     (colour),
        .render_req (render_req)
    );

    render_control i_render_control (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame      (frame),
        .render_req (render_req),
        .angle_x    (angle_x),
        .angle_y    (angle_y),
        .angle_z    (angle_z),
        .colour     (colour),
        .busy       (busy),
        .draw_cidx  (draw_cidx),
        .px         (px),
        .py         (py),
        .drawing    (drawing)
    );

    framebuffer i_framebuffer (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .sx        (sx),
        .sy        (sy),
        .de        (de),
        .hsync     (hsync),
        .vsync     (vsync),
        .we        (drawing),
        .px        (px),
        .py        (py),
        .cidx      (draw_cidx),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync)
    );

endmodule

// ==== verification/tb_cube_top.sv ====
// ********************
// cube renderer testbench with reference renderer and scanout checker
// ********************
`timescale 1ns/1ps

module tb_cube_top;

    localparam int h_active     = 640;
    localparam int h_total      = 800;
    localparam int h_sync_lo    = 656;
    localparam int h_sync_hi    = 751;
    localparam int v_active     = 480;
    localparam int v_total      = 525;
    localparam int v_sync_lo    = 490;
    localparam int v_sync_hi    = 491;
    localparam int frame_cycles = h_total * v_total;
    localparam int test_frames  = 8;  // blank frame, six renders, last check
    localparam int max_cycles   = test_frames * frame_cycles + 640_000;
    localparam int seed         = 89162;

    localparam logic [11:0] pal [16] = '{
        12'h000, 12'h123, 12'h725, 12'h085,
        12'hA53, 12'h655, 12'hCCC, 12'hFFE,
        12'hF05, 12'hFA0, 12'hFE2, 12'h0E3,
        12'h3AF, 12'h879, 12'hF7A, 12'hFCA
    };

    logic       clk_pix;
    logic       reset;
    logic       cfg_we;
    logic [1:0] cfg_addr;
    logic [7:0] cfg_data;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       busy;

    logic signed [7:0] tsin [17];
    logic [47:0]       tb_rom [12];
    logic [3:0]        ref_fb [19200];  // model framebuffer, 160x120
    logic [5:0]        shadow_ang [3];  // register contents as written
    logic [3:0]        shadow_col;
    logic [5:0]        held_ang [3];    // values the current render uses
    logic [3:0]        held_col;

    int   now_x;
    int   now_y;
    int   d1_x;
    int   d1_y;
    int   d2_x;
    int   d2_y;
    logic d1_ok;
    logic d2_ok;
    logic busy_q = 1'b0;
    logic req_open = 1'b0;  // colour write not yet served
    int   frames_done = 0;
    int   cycle_cnt = 0;

    cube_top i_dut (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b),
        .busy      (busy)
    );

    always #4 clk_pix = ~clk_pix;

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int sin_step(input int a);
        int i;
        i = a % 16;
        case (a / 16)  // quadrant
            0:       return int'(tsin[i]);
            1:       return int'(tsin[16 - i]);
            2:       return -int'(tsin[i]);
            default: return -int'(tsin[16 - i]);
        endcase
    endfunction

    function automatic int rom_byte(input int line_no, input int idx);
        logic [47:0]       word;
        logic signed [7:0] b;
        word = tb_rom[line_no];
        b    = word[47 - 8 * idx -: 8];
        return int'(b);
    endfunction

    // axis 0, 1, 2 turns the pairs (y, z), (z, x), (x, y)
    task automatic turn(input int axis, input int ang, inout int x, inout int y, inout int z);
        int s;
        int c;
        int u;
        int v;
        int nu;
        int nv;
        s = sin_step(ang);
        c = sin_step((ang + 16) % 64);
        case (axis)
            0: begin
                u = y;
                v = z;
            end
            1: begin
                u = z;
                v = x;
            end
            default: begin
                u = x;
                v = y;
            end
        endcase
        nu = (u * c - v * s) >>> 7;
        nv = (u * s + v * c) >>> 7;
        case (axis)
            0: begin
                y = nu;
                z = nv;
            end
            1: begin
                z = nu;
                x = nv;
            end
            default: begin
                x = nu;
                y = nv;
            end
        endcase
    endtask

    task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                              input logic [3:0] c);
        int dx;
        int dy;
        int e;
        int e2;
        int x;
        int y;
        dx = (x1 >= x0) ? x1 - x0 : x0 - x1;
        dy = (y1 >= y0) ? y0 - y1 : y1 - y0;  // minus |dy|
        e  = dx + dy;
        x  = x0;
        y  = y0;
        for (int n = 0; n < 1000; n++) begin
            if (x >= 0 && x < 160 && y >= 0 && y < 120) begin
                ref_fb[y * 160 + x] = c;
            end
            if (x == x1 && y == y1) break;
            e2 = 2 * e;
            if (e2 >= dy) begin
                e = e + dy;
                x = (x1 < x0) ? x - 1 : x + 1;
            end
            if (e2 <= dx) begin
                e = e + dx;
                y = (y1 < y0) ? y - 1 : y + 1;
            end
        end
    endtask

    task automatic model_render();
        int x;
        int y;
        int z;
        int xv [2];
        int yv [2];
        for (int l = 0; l < 12; l++) begin
            for (int k = 0; k < 2; k++) begin
                x = rom_byte(l, 3 * k) * 256;  // to Q8.8
                y = rom_byte(l, 3 * k + 1) * 256;
                z = rom_byte(l, 3 * k + 2) * 256;
                turn(0, held_ang[0], x, y, z);
                turn(1, held_ang[1], x, y, z);
                turn(2, held_ang[2], x, y, z);
                xv[k] = (x >>> 8) + 80;
                yv[k] = 60 - (y >>> 8);
            end
            model_line(xv[0], yv[0], xv[1], yv[1], held_col);
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [7:0] data);
        @(negedge clk_pix);
        cfg_we   <= 1'b1;
        cfg_addr <= addr;
        cfg_data <= data;
        @(negedge clk_pix);
        cfg_we <= 1'b0;
        if (addr == 2'd3) begin
            shadow_col = data[3:0];
            req_open   = 1'b1;
        end else begin
            shadow_ang[addr] = data[5:0];
        end
    endtask

    task automatic request_render();
        cfg_write(2'd0, 8'($urandom_range(0, 63)));
        cfg_write(2'd1, 8'($urandom_range(0, 63)));
        cfg_write(2'd2, 8'($urandom_range(0, 63)));
        cfg_write(2'd3, 8'($urandom_range(1, 15)));
    endtask

    task automatic wait_busy(input logic level);
        do begin
            @(negedge clk_pix);
        end while (busy !== level);
    endtask

    task automatic wait_frames(input int n);
        int target;
        @(posedge clk_pix);
        target = frames_done + n;
        while (frames_done < target) begin
            @(posedge clk_pix);
        end
    endtask

    task automatic hold_config();
        held_ang = shadow_ang;
        held_col = shadow_col;
    endtask

    // the model follows each render during vertical blank
    task automatic follow_render();
        wait_busy(1'b1);
        hold_config();
        wait_busy(1'b0);
        model_render();
    endtask

    // outputs show the scan position of two cycles earlier
    always @(negedge clk_pix) begin : scan_check
        logic [11:0] exp_rgb;
        logic        exp_hs;
        logic        exp_vs;
        if (reset) begin
            now_x = 0;
            now_y = 0;
            d1_ok = 1'b0;
            d2_ok = 1'b0;
        end else begin
            d2_ok = d1_ok;
            d2_x  = d1_x;
            d2_y  = d1_y;
            d1_ok = 1'b1;
            d1_x  = now_x;
            d1_y  = now_y;
            if (now_x == h_total - 1) begin
                now_x = 0;
                now_y = (now_y == v_total - 1) ? 0 : now_y + 1;
            end else begin
                now_x = now_x + 1;
            end
        end
        exp_rgb = 12'h000;
        exp_hs  = 1'b1;
        exp_vs  = 1'b1;
        if (d2_ok) begin
            exp_hs = !(d2_x >= h_sync_lo && d2_x <= h_sync_hi);
            exp_vs = !(d2_y >= v_sync_lo && d2_y <= v_sync_hi);
            if (d2_x < h_active && d2_y < v_active) begin
                exp_rgb = pal[ref_fb[(d2_y / 4) * 160 + d2_x / 4]];
            end
        end
        assert (vga_hsync === exp_hs) else report_error($sformatf(
            "hsync %b at (%0d,%0d), expected %b", vga_hsync, d2_x, d2_y, exp_hs));
        assert (vga_vsync === exp_vs) else report_error($sformatf(
            "vsync %b at (%0d,%0d), expected %b", vga_vsync, d2_x, d2_y, exp_vs));
        assert ({vga_r, vga_g, vga_b} === exp_rgb) else report_error($sformatf(
            "rgb %h at (%0d,%0d), expected %h", {vga_r, vga_g, vga_b}, d2_x, d2_y, exp_rgb));
        if (busy === 1'b1 && !busy_q) begin  // render may only start at vblank
            assert (now_x == 1 && now_y == v_active) else report_error($sformatf(
                "busy rose at (%0d,%0d), expected (1,%0d)", now_x, now_y, v_active));
            assert (req_open) else report_error($sformatf(
                "busy rose at (%0d,%0d) with no colour write pending", now_x, now_y));
            req_open = 1'b0;
        end
        busy_q = (busy === 1'b1);
        if (d2_ok && d2_x == h_total - 1 && d2_y == v_total - 1) begin
            frames_done = frames_done + 1;
        end
    end

    always @(posedge clk_pix) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: render or test did not finish");
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(seed));
        clk_pix  = 1'b0;
        reset    = 1'b1;
        cfg_we   = 1'b0;
        cfg_addr = 2'd0;
        cfg_data = 8'd0;
        $readmemh("rtl/sine.mem", tsin);
        $readmemh("rtl/cube.mem", tb_rom);
        for (int i = 0; i < 19200; i++) begin
            ref_fb[i] = 4'd0;
        end
        shadow_ang = '{6'd0, 6'd0, 6'd0};
        shadow_col = 4'hf;
        hold_config();

        repeat (16) @(negedge clk_pix);
        reset <= 1'b0;
        @(negedge clk_pix);
        assert (busy === 1'b0) else report_error($sformatf("busy %b after reset", busy));

        wait_frames(1);  // blank frame
        cfg_write(2'd3, 8'($urandom_range(1, 15)));  // angles still 0
        follow_render();

        repeat (3) begin
            request_render();
            follow_render();
        end

        // new values written while a render is running
        request_render();
        wait_busy(1'b1);
        hold_config();
        request_render();
        assert (busy === 1'b1) else report_error("render ended before the late writes");
        wait_busy(1'b0);
        model_render();
        follow_render();  // the late request
        wait_frames(2);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== rtl/sine.mem ====
// quarter-wave sine, round(127 * sin(pi * k / 32)) for k = 0..16, Q1.7
00
0C
19
25
31
3C
47
51
5A
62
6A
70
75
7A
7D
7E
7F

// ==== rtl/cube.mem ====
// one cube edge per line: x0 y0 z0 x1 y1 z1, signed bytes, vertices at +-40
D8D8D828D8D8
28D8D82828D8
2828D8D828D8
D828D8D8D8D8
D8D82828D828
28D828282828
282828D82828
D82828D8D828
D8D8D8D8D828
28D8D828D828
2828D8282828
D828D8D82828

// ==== vlog.f ====
rtl/display_pkg.sv
rtl/render_pkg.sv
rtl/display_timings.sv
rtl/framebuffer.sv
rtl/rotate.sv
rtl/draw_line.sv
rtl/render_config.sv
rtl/render_control.sv
rtl/cube_top.sv
verification/tb_cube_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cube_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from vlog.f, run, check $(LOG)"
	@echo "  clean  remove build output, copied memory files and $(LOG)"
	@echo "  help   show this list"

# the RTL loads sine.mem and cube.mem from the run directory
test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f vlog.f
	cp rtl/sine.mem rtl/cube.mem .
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG) sine.mem cube.mem
